//--- common/hdc_pkg.sv
package hdc_pkg;

    // ------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------
    localparam int CORE_COUNT = 4;
    localparam int DIM        = 64;
    localparam int ITEM_DEPTH = 64;
    // one core's slice of an input beat
    localparam int WORD_W     = 16;
    // signed bundling counter, round limited to 127 words
    localparam int COUNT_W    = 8;
    localparam int IDX_W      = $clog2(ITEM_DEPTH);
    localparam int CORE_IDX_W = $clog2(CORE_COUNT);

    // ------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------
    typedef logic [31:0]                  axil_word_t;
    typedef logic [CORE_COUNT*WORD_W-1:0] axis_word_t;
    typedef logic [31:0]                  rng_t;
    typedef logic [DIM-1:0]               hv_t;
    typedef logic [IDX_W-1:0]             item_idx_t;
    // 0 to ITEM_DEPTH entries
    typedef logic [IDX_W:0]               item_count_t;
    typedef logic signed [COUNT_W-1:0]    count_t;
    typedef logic [CORE_IDX_W-1:0]        core_idx_t;

    // xorshift32 start value, reloaded on every gen start
    localparam rng_t GEN_SEED = 32'h2545f491;

    // register map, byte offsets
    localparam axil_word_t REG_MODE       = 32'h0000_0000;
    localparam axil_word_t REG_ITEM_COUNT = 32'h0000_0004;

    // ------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------
    // one core's share of an input beat
    typedef struct packed {
        logic      strobe;
        logic      last;
        item_idx_t idx;
    } lane_cmd_t;

    // broadcast write into every item memory
    typedef struct packed {
        logic      en;
        item_idx_t addr;
        hv_t       data;
    } item_wr_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_AW_SEEN,
        ST_W_SEEN,
        ST_WRITE_RESP,
        ST_READ_ADDR,
        ST_READ_DATA
    } axil_state_t;

endpackage

//--- encoder_core/encoder_core.sv
`timescale 1ns/10ps

module encoder_core (
    input  logic               S_AXI_ACLK,
    input  logic               S_AXI_ARESETN,
    input  hdc_pkg::item_wr_t  item_wr,
    input  hdc_pkg::lane_cmd_t lane_cmd,
    output hdc_pkg::hv_t       result,
    output logic               result_valid
);
    import hdc_pkg::*;

    hv_t    item_mem [ITEM_DEPTH];
    hv_t    item_hv;
    count_t cnt      [DIM];
    count_t cnt_next [DIM];

    // ------------------------------------------------------------
    // item memory
    // ------------------------------------------------------------
    always_ff @(posedge S_AXI_ACLK) begin
        if (item_wr.en) begin
            item_mem[item_wr.addr] <= item_wr.data;
        end
    end

    // async lookup, command is already registered
    assign item_hv = item_mem[lane_cmd.idx];

    // ------------------------------------------------------------
    // bundling
    // ------------------------------------------------------------
    // one up where the bit is set, one down where clear
    always_comb begin
        for (int d = 0; d < DIM; d++) begin
            if (item_hv[d]) begin
                cnt_next[d] = cnt[d] + count_t'(1);
            end else begin
                cnt_next[d] = cnt[d] - count_t'(1);
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            for (int d = 0; d < DIM; d++) begin
                cnt[d] <= '0;
            end
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (lane_cmd.strobe && lane_cmd.last) begin
                // sign of the updated count, ties go to 0
                for (int d = 0; d < DIM; d++) begin
                    result[d] <= (cnt_next[d] > count_t'(0));
                    cnt[d]    <= '0;
                end
                result_valid <= 1'b1;
            end else if (lane_cmd.strobe) begin
                for (int d = 0; d < DIM; d++) begin
                    cnt[d] <= cnt_next[d];
                end
            end
        end
    end

endmodule

//--- flist.f
+incdir+verification
common/hdc_pkg.sv
hw/axil_regs.sv
hw/item_generator.sv
hw/stream_intake.sv
encoder_core/encoder_core.sv
hw/result_serializer.sv
hw/hdc_top.sv
verification/tb_hdc_top.sv

//--- hw/axil_regs.sv
`timescale 1ns/10ps

module axil_regs (
    input  logic                 S_AXI_ACLK,
    input  logic                 S_AXI_ARESETN,
    input  hdc_pkg::axil_word_t  S_AXI_AWADDR,
    input  logic                 S_AXI_AWVALID,
    output logic                 S_AXI_AWREADY,
    input  hdc_pkg::axil_word_t  S_AXI_WDATA,
    input  logic [3:0]           S_AXI_WSTRB,
    input  logic                 S_AXI_WVALID,
    output logic                 S_AXI_WREADY,
    input  logic                 S_AXI_BREADY,
    output logic [1:0]           S_AXI_BRESP,
    output logic                 S_AXI_BVALID,
    input  hdc_pkg::axil_word_t  S_AXI_ARADDR,
    input  logic                 S_AXI_ARVALID,
    output logic                 S_AXI_ARREADY,
    input  logic                 S_AXI_RREADY,
    output hdc_pkg::axil_word_t  S_AXI_RDATA,
    output logic [1:0]           S_AXI_RRESP,
    output logic                 S_AXI_RVALID,
    input  logic                 gen_done,
    output logic                 run,
    output logic                 gen,
    output logic                 gen_start,
    output hdc_pkg::item_count_t item_count
);
    import hdc_pkg::*;

    axil_state_t state;
    // address or data that arrived first
    axil_word_t  aw_addr;
    axil_word_t  w_data;
    logic [3:0]  w_strb;
    axil_word_t  ar_addr;
    // write as seen on the accepting edge
    logic        wr_fire;
    axil_word_t  wr_addr;
    axil_word_t  wr_data;
    logic [3:0]  wr_strb;
    logic        wr_en;

    // ------------------------------------------------------------
    // handshake outputs
    // ------------------------------------------------------------
    assign S_AXI_AWREADY = (state == ST_IDLE) || (state == ST_W_SEEN);
    assign S_AXI_WREADY  = (state == ST_IDLE) || (state == ST_AW_SEEN);
    assign S_AXI_ARREADY = (state == ST_IDLE);
    assign S_AXI_BVALID  = (state == ST_WRITE_RESP);
    assign S_AXI_RVALID  = (state == ST_READ_DATA);
    // always okay
    assign S_AXI_BRESP   = 2'b00;
    assign S_AXI_RRESP   = 2'b00;

    // both halves present on this edge
    assign wr_fire = ((state == ST_IDLE) && S_AXI_AWVALID && S_AXI_WVALID)
                  || ((state == ST_AW_SEEN) && S_AXI_WVALID)
                  || ((state == ST_W_SEEN) && S_AXI_AWVALID);
    assign wr_addr = (state == ST_AW_SEEN) ? aw_addr : S_AXI_AWADDR;
    assign wr_data = (state == ST_W_SEEN) ? w_data : S_AXI_WDATA;
    assign wr_strb = (state == ST_W_SEEN) ? w_strb : S_AXI_WSTRB;
    // every field sits in byte 0
    assign wr_en   = wr_fire && wr_strb[0];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state   <= ST_IDLE;
            aw_addr <= '0;
            w_data  <= '0;
            w_strb  <= '0;
            ar_addr <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (S_AXI_AWVALID && S_AXI_WVALID) begin
                        state <= ST_WRITE_RESP;
                    end else if (S_AXI_AWVALID) begin
                        state   <= ST_AW_SEEN;
                        aw_addr <= S_AXI_AWADDR;
                    end else if (S_AXI_WVALID) begin
                        state  <= ST_W_SEEN;
                        w_data <= S_AXI_WDATA;
                        w_strb <= S_AXI_WSTRB;
                    end else if (S_AXI_ARVALID) begin
                        state   <= ST_READ_ADDR;
                        ar_addr <= S_AXI_ARADDR;
                    end
                end
                ST_AW_SEEN: if (S_AXI_WVALID) state <= ST_WRITE_RESP;
                ST_W_SEEN: if (S_AXI_AWVALID) state <= ST_WRITE_RESP;
                ST_WRITE_RESP: if (S_AXI_BREADY) state <= ST_IDLE;
                // one cycle for the read mux
                ST_READ_ADDR: state <= ST_READ_DATA;
                ST_READ_DATA: if (S_AXI_RREADY) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // register file
    // ------------------------------------------------------------
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            run        <= 1'b0;
            gen        <= 1'b0;
            gen_start  <= 1'b0;
            item_count <= '0;
        end else begin
            gen_start <= 1'b0;
            if (wr_en && ({wr_addr[31:2], 2'b00} == REG_MODE)) begin
                run       <= wr_data[1];
                gen       <= wr_data[0];
                gen_start <= wr_data[0];
            end else if (gen_done) begin
                // generator finished filling the memories
                gen <= 1'b0;
            end
            if (wr_en && ({wr_addr[31:2], 2'b00} == REG_ITEM_COUNT)) begin
                item_count <= item_count_t'(wr_data);
            end
        end
    end

    // read mux, sampled while in read_addr
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            S_AXI_RDATA <= '0;
        end else if (state == ST_READ_ADDR) begin
            case ({ar_addr[31:2], 2'b00})
                REG_MODE:       S_AXI_RDATA <= {30'd0, run, gen};
                REG_ITEM_COUNT: S_AXI_RDATA <= axil_word_t'(item_count);
                default:        S_AXI_RDATA <= '0;
            endcase
        end
    end

endmodule

//--- hw/hdc_top.sv
`timescale 1ns/10ps

module hdc_top (
    input  logic                S_AXI_ACLK,
    input  logic                S_AXI_ARESETN,
    input  hdc_pkg::axil_word_t S_AXI_AWADDR,
    input  logic                S_AXI_AWVALID,
    output logic                S_AXI_AWREADY,
    input  hdc_pkg::axil_word_t S_AXI_WDATA,
    input  logic [3:0]          S_AXI_WSTRB,
    input  logic                S_AXI_WVALID,
    output logic                S_AXI_WREADY,
    input  logic                S_AXI_BREADY,
    output logic [1:0]          S_AXI_BRESP,
    output logic                S_AXI_BVALID,
    input  hdc_pkg::axil_word_t S_AXI_ARADDR,
    input  logic                S_AXI_ARVALID,
    output logic                S_AXI_ARREADY,
    input  logic                S_AXI_RREADY,
    output hdc_pkg::axil_word_t S_AXI_RDATA,
    output logic [1:0]          S_AXI_RRESP,
    output logic                S_AXI_RVALID,
    input  logic                M_AXIS_TREADY,
    output hdc_pkg::hv_t        M_AXIS_TDATA,
    output logic                M_AXIS_TVALID,
    output logic                M_AXIS_TLAST,
    input  hdc_pkg::axis_word_t S_AXIS_TDATA,
    input  logic                S_AXIS_TVALID,
    input  logic                S_AXIS_TLAST,
    output logic                S_AXIS_TREADY
);
    import hdc_pkg::*;

    // mode and generator handshake
    logic        run;
    logic        gen;
    logic        gen_start;
    logic        gen_done;
    item_count_t item_count;
    item_wr_t    item_wr;
    // round flow
    lane_cmd_t [CORE_COUNT-1:0] lane_cmds;
    hv_t       [CORE_COUNT-1:0] core_results;
    logic      [CORE_COUNT-1:0] core_valid;
    logic                       drain_done;

    axil_regs i_axil_regs (.*);

    item_generator i_item_generator (.*);

    stream_intake i_stream_intake (.*);

    // ------------------------------------------------------------
    // encoder cores, one word of each beat apiece
    // ------------------------------------------------------------
    for (genvar i = 0; i < CORE_COUNT; i++) begin : g_core
        encoder_core i_encoder_core (
            .S_AXI_ACLK    (S_AXI_ACLK),
            .S_AXI_ARESETN (S_AXI_ARESETN),
            .item_wr       (item_wr),
            .lane_cmd      (lane_cmds[i]),
            .result        (core_results[i]),
            .result_valid  (core_valid[i])
        );
    end

    // cores run in lockstep, core 0 speaks for all
    result_serializer i_result_serializer (
        .results      (core_results),
        .result_valid (core_valid[0]),
        .*
    );

endmodule

//--- hw/item_generator.sv
`timescale 1ns/10ps

module item_generator (
    input  logic                 S_AXI_ACLK,
    input  logic                 S_AXI_ARESETN,
    input  logic                 gen_start,
    input  hdc_pkg::item_count_t item_count,
    output hdc_pkg::item_wr_t    item_wr,
    output logic                 gen_done
);
    import hdc_pkg::*;

    rng_t        xs_state;
    // two steps per entry, low half first
    rng_t        xs_lo;
    rng_t        xs_hi;
    item_count_t wr_cnt;
    logic        active;

    // shifts 13 left, 17 right, 5 left
    function automatic rng_t xorshift32(input rng_t x);
        rng_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign xs_lo = xorshift32(xs_state);
    assign xs_hi = xorshift32(xs_lo);

    // same write goes to every core
    assign item_wr.en   = active;
    assign item_wr.addr = item_idx_t'(wr_cnt);
    assign item_wr.data = hv_t'({xs_hi, xs_lo});

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            xs_state <= '0;
            wr_cnt   <= '0;
            active   <= 1'b0;
            gen_done <= 1'b0;
        end else begin
            gen_done <= 1'b0;
            if (gen_start) begin
                xs_state <= GEN_SEED;
                wr_cnt   <= '0;
                active   <= (item_count != '0);
                // nothing to write, finish at once
                gen_done <= (item_count == '0);
            end else if (active) begin
                xs_state <= xs_hi;
                wr_cnt   <= wr_cnt + 1'b1;
                if (wr_cnt == item_count - 1'b1) begin
                    active   <= 1'b0;
                    gen_done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/result_serializer.sv
`timescale 1ns/10ps

module result_serializer (
    input  logic                                   S_AXI_ACLK,
    input  logic                                   S_AXI_ARESETN,
    input  hdc_pkg::hv_t [hdc_pkg::CORE_COUNT-1:0] results,
    input  logic                                   result_valid,
    input  logic                                   M_AXIS_TREADY,
    output hdc_pkg::hv_t                           M_AXIS_TDATA,
    output logic                                   M_AXIS_TVALID,
    output logic                                   M_AXIS_TLAST,
    output logic                                   drain_done
);
    import hdc_pkg::*;

    hv_t [CORE_COUNT-1:0] held;
    // core now on the bus
    core_idx_t            ptr;
    logic                 tvalid;
    logic                 at_end;
    logic                 handshake;

    assign at_end        = (ptr == core_idx_t'(CORE_COUNT - 1));
    assign handshake     = tvalid && M_AXIS_TREADY;
    assign M_AXIS_TVALID = tvalid;
    assign M_AXIS_TDATA  = held[ptr];
    assign M_AXIS_TLAST  = tvalid && at_end;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            held       <= '0;
            ptr        <= '0;
            tvalid     <= 1'b0;
            drain_done <= 1'b0;
        end else begin
            drain_done <= 1'b0;
            if (result_valid) begin
                // all cores finish on the same edge
                held   <= results;
                ptr    <= '0;
                tvalid <= 1'b1;
            end else if (handshake) begin
                if (at_end) begin
                    tvalid     <= 1'b0;
                    ptr        <= '0;
                    drain_done <= 1'b1;
                end else begin
                    ptr <= ptr + 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/stream_intake.sv
`timescale 1ns/10ps

module stream_intake (
    input  logic                                         S_AXI_ACLK,
    input  logic                                         S_AXI_ARESETN,
    input  logic                                         run,
    input  logic                                         gen,
    input  hdc_pkg::axis_word_t                          S_AXIS_TDATA,
    input  logic                                         S_AXIS_TVALID,
    input  logic                                         S_AXIS_TLAST,
    input  logic                                         drain_done,
    output logic                                         S_AXIS_TREADY,
    output hdc_pkg::lane_cmd_t [hdc_pkg::CORE_COUNT-1:0] lane_cmds
);
    import hdc_pkg::*;

    // round closed, waiting for the output side
    logic busy;
    logic accept;

    assign S_AXIS_TREADY = run && !gen && !busy;
    assign accept        = S_AXIS_TVALID && S_AXIS_TREADY;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            busy <= 1'b0;
        end else if (accept && S_AXIS_TLAST) begin
            busy <= 1'b1;
        end else if (drain_done) begin
            busy <= 1'b0;
        end
    end

    // split the beat, low word to core 0
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            lane_cmds <= '0;
        end else begin
            for (int i = 0; i < CORE_COUNT; i++) begin
                lane_cmds[i].strobe <= accept;
                lane_cmds[i].last   <= accept && S_AXIS_TLAST;
                // index lives in the low bits of each word
                lane_cmds[i].idx    <= S_AXIS_TDATA[i*WORD_W +: IDX_W];
            end
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the hdc encoder testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_hdc_top \
    --Mdir "$BUILD_DIR" -o tb_hdc_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BUILD_DIR/tb_hdc_top" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Finished with no errors" "$LOG_FILE"; then
    exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1

//--- verification/tb_hdc_model.svh
`ifndef TB_HDC_MODEL_SVH
`define TB_HDC_MODEL_SVH

    // ------------------------------------------------------------
    // stimulus random source
    // ------------------------------------------------------------
    logic [31:0] lfsr_state = 32'ha8f56637;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // n fresh bits, one step per bit, newest bit lowest
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // ------------------------------------------------------------
    // reference item vectors and bundling tallies
    // ------------------------------------------------------------
    localparam logic [31:0] ITEM_SEED = 32'h2545f491;

    hv_t model_items [ITEM_DEPTH];
    // wide tallies, no wrap to worry about
    int  tally [CORE_COUNT][DIM];

    // xorshift32 with shifts 13, 17, 5
    function automatic logic [31:0] xorshift_next(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    // entry k from draws 2k and 2k+1, later draw on top
    function automatic void build_item_table(input int count);
        logic [31:0] s;
        logic [31:0] lo;
        s = ITEM_SEED;
        for (int k = 0; k < count; k++) begin
            lo = xorshift_next(s);
            s  = xorshift_next(lo);
            model_items[k] = {s, lo};
        end
    endfunction

    function automatic void clear_tallies();
        for (int c = 0; c < CORE_COUNT; c++) begin
            for (int d = 0; d < DIM; d++) begin
                tally[c][d] = 0;
            end
        end
    endfunction

    // up on a set bit, down on a clear bit
    function automatic void tally_item(input int core, input int idx);
        for (int d = 0; d < DIM; d++) begin
            if (model_items[idx][d]) begin
                tally[core][d] = tally[core][d] + 1;
            end else begin
                tally[core][d] = tally[core][d] - 1;
            end
        end
    endfunction

    // strictly positive tally gives a 1
    function automatic hv_t tally_sign(input int core);
        hv_t v;
        for (int d = 0; d < DIM; d++) begin
            v[d] = (tally[core][d] > 0);
        end
        return v;
    endfunction

`endif

//--- verification/tb_hdc_top.sv
`timescale 1ns/10ps

module tb_hdc_top;
    import hdc_pkg::*;

    localparam int ROUNDS         = 20;
    // entries generated, indices stay below this
    localparam int ITEMS_USED     = 40;
    // registers ~60, gen ~45, 20 rounds of up to 8 beats plus stalled outputs
    localparam int TIMEOUT_CYCLES = 4000;

    logic       S_AXI_ACLK;
    logic       S_AXI_ARESETN;
    axil_word_t S_AXI_AWADDR;
    logic       S_AXI_AWVALID;
    logic       S_AXI_AWREADY;
    axil_word_t S_AXI_WDATA;
    logic [3:0] S_AXI_WSTRB;
    logic       S_AXI_WVALID;
    logic       S_AXI_WREADY;
    logic       S_AXI_BREADY;
    logic [1:0] S_AXI_BRESP;
    logic       S_AXI_BVALID;
    axil_word_t S_AXI_ARADDR;
    logic       S_AXI_ARVALID;
    logic       S_AXI_ARREADY;
    logic       S_AXI_RREADY;
    axil_word_t S_AXI_RDATA;
    logic [1:0] S_AXI_RRESP;
    logic       S_AXI_RVALID;
    logic       M_AXIS_TREADY = 1'b0;
    hv_t        M_AXIS_TDATA;
    logic       M_AXIS_TVALID;
    logic       M_AXIS_TLAST;
    axis_word_t S_AXIS_TDATA;
    logic       S_AXIS_TVALID;
    logic       S_AXIS_TLAST;
    logic       S_AXIS_TREADY;

    `include "tb_hdc_model.svh"

    // expected output beats, core 0 first
    hv_t exp_q [$];
    bit  run_enabled;
    bit  gen_pending;
    bit  round_closed;
    bit  tvalid_seen;
    int  out_beat;
    int  sample_no;
    int  accept_sample;
    int  cycle_count;

    hdc_top i_hdc_top (.*);

    always #50 S_AXI_ACLK = ~S_AXI_ACLK;

    // ------------------------------------------------------------
    // failure reporting
    // ------------------------------------------------------------
    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic flag_error(input string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        abort_run();
    endtask

    // ------------------------------------------------------------
    // bus tasks, called 10 ns after an edge
    // ------------------------------------------------------------
    task automatic axil_write(input axil_word_t addr, input axil_word_t data);
        S_AXI_AWADDR  = addr;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WDATA   = data;
        S_AXI_WSTRB   = 4'hf;
        S_AXI_WVALID  = 1'b1;
        S_AXI_BREADY  = 1'b1;
        do @(posedge S_AXI_ACLK); while (!(S_AXI_AWREADY && S_AXI_WREADY));
        #10;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        do @(posedge S_AXI_ACLK); while (!S_AXI_BVALID);
        assert (S_AXI_BRESP == 2'b00) else flag_error("write response not OKAY");
        #10;
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic axil_read(input axil_word_t addr, output axil_word_t data);
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        S_AXI_RREADY  = 1'b1;
        do @(posedge S_AXI_ACLK); while (!S_AXI_ARREADY);
        #10;
        S_AXI_ARVALID = 1'b0;
        do @(posedge S_AXI_ACLK); while (!S_AXI_RVALID);
        assert (S_AXI_RRESP == 2'b00) else flag_error("read response not OKAY");
        data = S_AXI_RDATA;
        #10;
        S_AXI_RREADY = 1'b0;
    endtask

    task automatic send_beat(input axis_word_t data, input logic last);
        S_AXIS_TDATA  = data;
        S_AXIS_TLAST  = last;
        S_AXIS_TVALID = 1'b1;
        do @(posedge S_AXI_ACLK); while (!S_AXIS_TREADY);
        #10;
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;
    endtask

    // one round of 1 to 8 beats, expected signs queued before the last beat
    task automatic run_round();
        int          nbeats;
        int          idx;
        logic [31:0] junk;
        axis_word_t  beat;
        nbeats = 1 + int'(take_bits(3));
        clear_tallies();
        for (int b = 0; b < nbeats; b++) begin
            beat = '0;
            for (int c = 0; c < CORE_COUNT; c++) begin
                idx = int'(take_bits(IDX_W));
                // fold the top of the range back below 40
                if (idx >= ITEMS_USED) begin
                    idx = idx - ITEMS_USED;
                end
                // noise in the unused upper bits of the word
                junk = take_bits(WORD_W - IDX_W);
                beat[c*WORD_W +: WORD_W] = WORD_W'(junk << IDX_W) | WORD_W'(idx);
                tally_item(c, idx);
            end
            if (b == nbeats - 1) begin
                for (int c = 0; c < CORE_COUNT; c++) begin
                    exp_q.push_back(tally_sign(c));
                end
            end
            send_beat(beat, b == nbeats - 1);
        end
    endtask

    // ------------------------------------------------------------
    // output side and stream ready checks
    // ------------------------------------------------------------
    property hold_while_stalled;
        @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (M_AXIS_TVALID && !M_AXIS_TREADY) |=>
            (M_AXIS_TVALID && $stable(M_AXIS_TDATA) && $stable(M_AXIS_TLAST));
    endproperty

    assert property (hold_while_stalled)
        else flag_error("output beat changed or dropped while stalled");

    always @(posedge S_AXI_ACLK) begin
        logic next_ready;
        sample_no = sample_no + 1;
        if (S_AXI_ARESETN) begin
            if (!run_enabled) begin
                assert (!S_AXIS_TREADY) else flag_error("input ready with run clear");
            end
            if (gen_pending) begin
                assert (!S_AXIS_TREADY) else flag_error("input ready during gen");
            end
            if (round_closed) begin
                assert (!S_AXIS_TREADY) else flag_error("input ready before drain");
            end
            // valid rises two cycles after the closing edge
            if (M_AXIS_TVALID && !tvalid_seen) begin
                assert (sample_no == accept_sample + 3)
                    else flag_error($sformatf("output valid %0d edges after last beat",
                                              sample_no - accept_sample));
            end
            if (M_AXIS_TVALID && M_AXIS_TREADY) begin
                if (exp_q.size() == 0) begin
                    $display("an output beat arrived with no result pending");
                    abort_run();
                end
                assert (M_AXIS_TDATA == exp_q[0])
                    else flag_error($sformatf("core %0d result %h, expected %h",
                                              out_beat, M_AXIS_TDATA, exp_q[0]));
                assert (M_AXIS_TLAST == (out_beat == CORE_COUNT - 1))
                    else flag_error($sformatf("TLAST wrong on beat %0d", out_beat));
                void'(exp_q.pop_front());
                if (out_beat == CORE_COUNT - 1) begin
                    out_beat     = 0;
                    round_closed = 1'b0;
                end else begin
                    out_beat = out_beat + 1;
                end
            end
            if (S_AXIS_TVALID && S_AXIS_TREADY && S_AXIS_TLAST) begin
                round_closed  = 1'b1;
                accept_sample = sample_no;
            end
            tvalid_seen = M_AXIS_TVALID;
        end
        next_ready = (take_bits(1) != '0);
        #10;
        M_AXIS_TREADY = next_ready;
    end

    // watchdog
    always @(posedge S_AXI_ACLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        axil_word_t rdata;
        S_AXI_ACLK    = 1'b0;
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        S_AXIS_TDATA  = '0;
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;
        repeat (10) @(posedge S_AXI_ACLK);
        #10;
        S_AXI_ARESETN = 1'b1;

        // register map
        axil_read(REG_MODE, rdata);
        assert (rdata == '0) else flag_error("mode register not zero after reset");
        axil_write(REG_ITEM_COUNT, axil_word_t'(ITEMS_USED));
        axil_read(REG_ITEM_COUNT, rdata);
        assert (rdata == axil_word_t'(ITEMS_USED)) else flag_error("item count readback");
        axil_read(32'h0000_0010, rdata);
        assert (rdata == '0) else flag_error("unmapped offset not zero");

        // gen with run set, memories busy for item_count + 1 cycles
        build_item_table(ITEMS_USED);
        run_enabled = 1'b1;
        gen_pending = 1'b1;
        axil_write(REG_MODE, 32'h0000_0003);
        repeat (ITEMS_USED) @(posedge S_AXI_ACLK);
        #10;
        gen_pending = 1'b0;
        do axil_read(REG_MODE, rdata); while (rdata[0]);
        assert (rdata[1]) else flag_error("run bit lost during gen");

        for (int r = 0; r < ROUNDS; r++) begin
            run_round();
        end
        do begin
            @(posedge S_AXI_ACLK);
            #10;
        end while (exp_q.size() != 0);

        // run cleared, a pending beat must not be taken
        axil_write(REG_MODE, 32'h0000_0000);
        run_enabled   = 1'b0;
        S_AXIS_TVALID = 1'b1;
        S_AXIS_TLAST  = 1'b1;
        repeat (20) @(posedge S_AXI_ACLK);
        #10;
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;

        $display("Finished with no errors");
        $finish;
    end

endmodule
